// ==== build.f ====
+incdir+logic
logic/riscvPkg.sv
logic/regFile.sv
logic/alu.sv
logic/decoder.sv
logic/fetchUnit.sv
logic/pipeControl.sv
logic/riscvCore.sv
test/clockGen.sv
test/tbRiscv.sv

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu
   import riscvPkg::*;
(
   input  word_t       a,
   input  word_t       b,
   input  aluOp_t      op,
   input  logic [2:0]  branchFunct,
   output word_t       result,
   output logic        condTrue
);

   logic [4:0] shamt;
   logic       signedLess;
   logic       unsignedLess;

   assign shamt        = b[4:0];
   assign signedLess   = $signed(a) < $signed(b);
   assign unsignedLess = a < b;

   always_comb
   begin
      case (op)
         ALU_SUB:   result = a - b;
         ALU_SLL:   result = a << shamt;
         ALU_SLT:   result = {31'b0, signedLess};
         ALU_SLTU:  result = {31'b0, unsignedLess};
         ALU_XOR:   result = a ^ b;
         ALU_SRL:   result = a >> shamt;
         ALU_SRA:   result = word_t'($signed(a) >>> shamt);
         ALU_OR:    result = a | b;
         ALU_AND:   result = a & b;
         ALU_PASSB: result = b;
         default:   result = a + b;
      endcase
   end

   // Branch condition from the same operands, funct3 encoding
   always_comb
   begin
      case (branchFunct)
         3'b000:  condTrue = (a == b);
         3'b001:  condTrue = (a != b);
         3'b100:  condTrue = signedLess;
         3'b101:  condTrue = !signedLess;
         3'b110:  condTrue = unsignedLess;
         3'b111:  condTrue = !unsignedLess;
         default: condTrue = 1'b0;
      endcase
   end

endmodule

// ==== logic/decoder.sv ====
`timescale 1ns/100ps

module decoder
   import riscvPkg::*;
(
   input  word_t      instr,
   output regAddr_t   rs1,
   output regAddr_t   rs2,
   output regAddr_t   rd,
   output word_t      imm,
   output aluOp_t     aluOp,
   output logic [1:0] aSel,
   output logic       bImm,
   output wbSel_t     wbSel,
   output logic       regWe,
   output logic       memWe,
   output logic       memRe,
   output logic       isBranch,
   output logic       isJal,
   output logic       isJalr,
   output logic       usesRs1,
   output logic       usesRs2
);

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       funct7b5;
   logic       writesRd;
   aluOp_t     arithOp;

   assign opcode   = instr[6:0];
   assign funct3   = instr[14:12];
   assign funct7b5 = instr[30];
   assign rs1      = instr[19:15];
   assign rs2      = instr[24:20];
   assign rd       = instr[11:7];

   // Sign-extended immediate by format
   always_comb
   begin
      case (opcode)
         OP_STORE:
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         OP_BRANCH:
            imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
         OP_LUI, OP_AUIPC:
            imm = {instr[31:12], 12'b0};
         OP_JAL:
            imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
         default:
            imm = {{20{instr[31]}}, instr[31:20]};
      endcase
   end

   // ALU op for register and immediate arithmetic
   // SUB only exists in register form, SRA in both
   always_comb
   begin
      case (funct3)
         3'b000:  arithOp = (opcode == OP_REG && funct7b5) ? ALU_SUB : ALU_ADD;
         3'b001:  arithOp = ALU_SLL;
         3'b010:  arithOp = ALU_SLT;
         3'b011:  arithOp = ALU_SLTU;
         3'b100:  arithOp = ALU_XOR;
         3'b101:  arithOp = funct7b5 ? ALU_SRA : ALU_SRL;
         3'b110:  arithOp = ALU_OR;
         default: arithOp = ALU_AND;
      endcase
   end

   always_comb
   begin
      aluOp    = ALU_ADD;
      aSel     = A_SEL_REG;
      bImm     = 1'b0;
      wbSel    = WB_ALU;
      writesRd = 1'b0;
      memWe    = 1'b0;
      memRe    = 1'b0;
      isBranch = 1'b0;
      isJal    = 1'b0;
      isJalr   = 1'b0;
      usesRs1  = 1'b0;
      usesRs2  = 1'b0;
      case (opcode)
         OP_LUI:
         begin
            aSel     = A_SEL_ZERO;
            bImm     = 1'b1;
            writesRd = 1'b1;
         end
         OP_AUIPC:
         begin
            // Immediate passes through, PC added in writeback
            aluOp    = ALU_PASSB;
            bImm     = 1'b1;
            wbSel    = WB_AUIPC;
            writesRd = 1'b1;
         end
         OP_JAL:
         begin
            // ALU forms the jump target from PC
            aSel     = A_SEL_PC;
            bImm     = 1'b1;
            wbSel    = WB_LINK;
            writesRd = 1'b1;
            isJal    = 1'b1;
         end
         OP_JALR:
         begin
            bImm     = 1'b1;
            wbSel    = WB_LINK;
            writesRd = 1'b1;
            isJalr   = 1'b1;
            usesRs1  = 1'b1;
         end
         OP_BRANCH:
         begin
            aluOp    = ALU_SUB;
            isBranch = 1'b1;
            usesRs1  = 1'b1;
            usesRs2  = 1'b1;
         end
         OP_LOAD:
         begin
            bImm     = 1'b1;
            wbSel    = WB_MEM;
            writesRd = 1'b1;
            memRe    = 1'b1;
            usesRs1  = 1'b1;
         end
         OP_STORE:
         begin
            bImm     = 1'b1;
            memWe    = 1'b1;
            usesRs1  = 1'b1;
            usesRs2  = 1'b1;
         end
         OP_IMM:
         begin
            aluOp    = arithOp;
            bImm     = 1'b1;
            writesRd = 1'b1;
            usesRs1  = 1'b1;
         end
         OP_REG:
         begin
            aluOp    = arithOp;
            writesRd = 1'b1;
            usesRs1  = 1'b1;
            usesRs2  = 1'b1;
         end
         default:
         begin
            aluOp    = ALU_ADD;
         end
      endcase
   end

   // Writes to x0 are dropped here so forwarding never matches x0
   assign regWe = writesRd && (rd != 5'd0);

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/100ps
`include "riscvCfg.svh"

module fetchUnit
   import riscvPkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic hold,
   input  logic redirect,
   input  pc_t  target,
   input  pc_t  pcX,
   output pc_t  pcF
);

   pc_t nextPc;

   // Redirect wins, then replay of the held execute address
   always_comb
   begin
      if (redirect)
         pcF = target;
      else if (hold)
         pcF = pcX;
      else
         pcF = nextPc;
   end

   // Target fetched again in the squashed slot, so it is not advanced here
   always_ff @(posedge clk)
   begin
      if (rst)
         nextPc <= `RESET_PC;
      else if (redirect)
         nextPc <= target;
      else if (!hold)
         nextPc <= pcF + pc_t'(4);
   end

   // Jump targets come from execute operands
   assert property (@(posedge clk) disable iff (rst) pcF[1:0] == 2'b00);

endmodule

// ==== logic/pipeControl.sv ====
`timescale 1ns/100ps

module pipeControl
   import riscvPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     stall,
   input  logic     redirect,
   input  regAddr_t rs1,
   input  regAddr_t rs2,
   input  logic     usesRs1,
   input  logic     usesRs2,
   input  regAddr_t rdW,
   input  logic     regWeW,
   output logic     forwardA,
   output logic     forwardB,
   output logic     advance,
   output logic     hold,
   output logic     squash
);

   // Writeback result bypasses the register file
   assign forwardA = usesRs1 && regWeW && (rdW == rs1);
   assign forwardB = usesRs2 && regWeW && (rdW == rs2);

   // Stall freezes fetch and execute as a unit
   assign hold    = stall;
   assign advance = !stall;

   // Held high through reset so the first execute slot is a bubble
   always_ff @(posedge clk)
   begin
      if (rst)
         squash <= 1'b1;
      else
         squash <= redirect && !stall;
   end

   // A squashed slot is a NOP and can never redirect again
   assert property (@(posedge clk) disable iff (rst) squash |=> !squash);

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/100ps

module regFile
   import riscvPkg::*;
(
   input  logic     clk,
   input  logic     we,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa,
   input  word_t    wd,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [32];

   // Single write port, x0 contents never observed
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         regs[wa] <= wd;
      end
   end

   // Combinational reads, x0 forced to zero
   assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// ==== logic/riscvCfg.svh ====
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// Byte address width carried by the program counter
`define PC_WIDTH 14

// First fetch address after reset
`define RESET_PC {`PC_WIDTH{1'b0}}

// ADDI x0,x0,0 used as the pipeline bubble
`define NOP_INSTR 32'h0000_0013

`endif

// ==== logic/riscvCore.sv ====
`timescale 1ns/100ps
`include "riscvCfg.svh"

module riscvCore
   import riscvPkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  stall,
   output pc_t   imemAddr,
   input  word_t imemRdata,
   output pc_t   dmemAddr,
   output word_t dmemWdata,
   output logic  dmemWe,
   output logic  dmemRe,
   input  word_t dmemRdata
);

   word_t      instrX;
   regAddr_t   rs1X;
   regAddr_t   rs2X;
   regAddr_t   rdX;
   word_t      immX;
   aluOp_t     aluOpX;
   logic [1:0] aSelX;
   logic       bImmX;
   wbSel_t     wbSelX;
   logic       regWeX;
   logic       memWeX;
   logic       memReX;
   logic       isBranchX;
   logic       isJalX;
   logic       isJalrX;
   logic       usesRs1X;
   logic       usesRs2X;
   word_t      rd1X;
   word_t      rd2X;
   word_t      rs2Val;
   word_t      opA;
   word_t      opB;
   word_t      aluResult;
   word_t      linkX;
   logic       condTrue;
   logic       takenX;
   logic       fetchRedirect;
   logic       forwardA;
   logic       forwardB;
   logic       advance;
   logic       hold;
   logic       squash;
   pc_t        pcF;
   pc_t        pcX;
   pc_t        branchTarget;
   pc_t        jumpTarget;
   word_t      resultW;
   word_t      linkW;
   word_t      wbValue;
   pc_t        pcW;
   regAddr_t   rdW;
   logic       regWeW;
   wbSel_t     wbSelW;

   // Synchronous imem output is the execute instruction
   assign instrX = squash ? `NOP_INSTR : imemRdata;

   decoder u_decoder (.instr(instrX), .rs1(rs1X), .rs2(rs2X), .rd(rdX), .imm(immX),
      .aluOp(aluOpX), .aSel(aSelX), .bImm(bImmX), .wbSel(wbSelX), .regWe(regWeX),
      .memWe(memWeX), .memRe(memReX), .isBranch(isBranchX), .isJal(isJalX),
      .isJalr(isJalrX), .usesRs1(usesRs1X), .usesRs2(usesRs2X));

   regFile u_regFile (.clk(clk), .we(regWeW), .ra1(rs1X), .ra2(rs2X), .wa(rdW),
      .wd(wbValue), .rd1(rd1X), .rd2(rd2X));

   pipeControl u_pipeControl (.clk(clk), .rst(rst), .stall(stall), .redirect(takenX),
      .rs1(rs1X), .rs2(rs2X), .usesRs1(usesRs1X), .usesRs2(usesRs2X), .rdW(rdW),
      .regWeW(regWeW), .forwardA(forwardA), .forwardB(forwardB), .advance(advance),
      .hold(hold), .squash(squash));

   // Operand muxes
   always_comb
   begin
      if (forwardA)
         opA = wbValue;
      else if (aSelX == A_SEL_ZERO)
         opA = '0;
      else if (aSelX == A_SEL_PC)
         opA = word_t'(pcX);
      else
         opA = rd1X;
   end

   assign rs2Val = forwardB ? wbValue : rd2X;
   assign opB    = bImmX ? immX : rs2Val;

   alu u_alu (.a(opA), .b(opB), .op(aluOpX), .branchFunct(instrX[14:12]),
      .result(aluResult), .condTrue(condTrue));

   // Branches use their own adder, the ALU is busy comparing
   assign branchTarget  = pcX + immX[`PC_WIDTH-1:0];
   assign jumpTarget    = isBranchX ? branchTarget : {aluResult[`PC_WIDTH-1:1], 1'b0};
   assign takenX        = (isBranchX && condTrue) || isJalX || isJalrX;
   assign fetchRedirect = takenX && advance;

   fetchUnit u_fetchUnit (.clk(clk), .rst(rst), .hold(hold), .redirect(fetchRedirect),
      .target(jumpTarget), .pcX(pcX), .pcF(pcF));

   assign imemAddr = pcF;

   // Address of the word now in execute
   always_ff @(posedge clk)
   begin
      if (rst)
         pcX <= `RESET_PC;
      else if (advance)
         pcX <= pcF;
   end

   assign linkX = word_t'(pcX) + 32'd4;

   // No data request while execute is frozen
   assign dmemAddr  = aluResult[`PC_WIDTH-1:0];
   assign dmemWdata = rs2Val;
   assign dmemWe    = memWeX && advance;
   assign dmemRe    = memReX && advance;

   // Stalled execute sends a bubble to writeback
   always_ff @(posedge clk)
   begin
      if (rst)
         regWeW <= 1'b0;
      else
         regWeW <= regWeX && advance;
   end

   always_ff @(posedge clk)
   begin
      rdW     <= rdX;
      wbSelW  <= wbSelX;
      resultW <= aluResult;
      linkW   <= linkX;
      pcW     <= pcX;
   end

   always_comb
   begin
      case (wbSelW)
         WB_MEM:   wbValue = dmemRdata;
         WB_LINK:  wbValue = linkW;
         WB_AUIPC: wbValue = word_t'(pcW) + resultW;
         default:  wbValue = resultW;
      endcase
   end

   assert property (@(posedge clk) disable iff (rst) !(dmemWe && dmemRe));

endmodule

// ==== logic/riscvPkg.sv ====
`include "riscvCfg.svh"

package riscvPkg;

   typedef logic [31:0]          word_t;
   typedef logic [`PC_WIDTH-1:0] pc_t;
   typedef logic [4:0]           regAddr_t;
   typedef logic [6:0]           opcode_t;
   typedef logic [3:0]           aluOp_t;
   typedef logic [1:0]           wbSel_t;

   // Major opcodes of the supported classes
   localparam opcode_t OP_LUI    = 7'b0110111;
   localparam opcode_t OP_AUIPC  = 7'b0010111;
   localparam opcode_t OP_JAL    = 7'b1101111;
   localparam opcode_t OP_JALR   = 7'b1100111;
   localparam opcode_t OP_BRANCH = 7'b1100011;
   localparam opcode_t OP_LOAD   = 7'b0000011;
   localparam opcode_t OP_STORE  = 7'b0100011;
   localparam opcode_t OP_IMM    = 7'b0010011;
   localparam opcode_t OP_REG    = 7'b0110011;

   // ALU codes, low bits follow funct3 where one exists
   localparam aluOp_t ALU_ADD   = 4'b0000;
   localparam aluOp_t ALU_SLL   = 4'b0001;
   localparam aluOp_t ALU_SLT   = 4'b0010;
   localparam aluOp_t ALU_SLTU  = 4'b0011;
   localparam aluOp_t ALU_XOR   = 4'b0100;
   localparam aluOp_t ALU_SRL   = 4'b0101;
   localparam aluOp_t ALU_OR    = 4'b0110;
   localparam aluOp_t ALU_AND   = 4'b0111;
   localparam aluOp_t ALU_SUB   = 4'b1000;
   localparam aluOp_t ALU_SRA   = 4'b1101;
   localparam aluOp_t ALU_PASSB = 4'b1111;

   // Writeback sources
   localparam wbSel_t WB_ALU   = 2'd0;
   localparam wbSel_t WB_MEM   = 2'd1;
   localparam wbSel_t WB_LINK  = 2'd2;
   localparam wbSel_t WB_AUIPC = 2'd3;

   // A operand sources, forwarding overrides the register path
   localparam logic [1:0] A_SEL_REG  = 2'd0;
   localparam logic [1:0] A_SEL_ZERO = 2'd1;
   localparam logic [1:0] A_SEL_PC   = 2'd2;

endpackage

// ==== test/clockGen.sv ====
`timescale 1ns/100ps

module clockGen
(
   output logic clk,
   output logic rst
);

   // 100 ns period
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset held over three rising edges, released just after the third
   initial
   begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// ==== test/tbRiscv.sv ====
`timescale 1ns/100ps
`include "riscvCfg.svh"

module tbRiscv
   import riscvPkg::*;
();

   // About 160 instructions retire, redirects and stall stay under four times that
   localparam int  MAX_CYCLES = 2000;
   localparam int  MEM_WORDS  = 2 ** (`PC_WIDTH - 2);
   localparam pc_t MARKER     = pc_t'(2044);

   // funct3 codes of the ALU operations and the branches
   localparam logic [2:0] F_ADD  = 3'd0;
   localparam logic [2:0] F_SLL  = 3'd1;
   localparam logic [2:0] F_SLT  = 3'd2;
   localparam logic [2:0] F_SLTU = 3'd3;
   localparam logic [2:0] F_XOR  = 3'd4;
   localparam logic [2:0] F_SR   = 3'd5;
   localparam logic [2:0] F_OR   = 3'd6;
   localparam logic [2:0] F_AND  = 3'd7;
   localparam logic [2:0] F_BEQ  = 3'd0;
   localparam logic [2:0] F_BNE  = 3'd1;
   localparam logic [2:0] F_BLT  = 3'd4;
   localparam logic [2:0] F_BGE  = 3'd5;
   localparam logic [2:0] F_BLTU = 3'd6;
   localparam logic [2:0] F_BGEU = 3'd7;

   logic        clk;
   logic        rst;
   logic        stall;
   pc_t         imemAddr;
   word_t       imemRdata;
   pc_t         dmemAddr;
   word_t       dmemWdata;
   logic        dmemWe;
   logic        dmemRe;
   word_t       dmemRdata;
   word_t       imem [MEM_WORDS];
   word_t       dmem [MEM_WORDS];
   word_t       refMem [MEM_WORDS];
   pc_t         expAddrQ [$];
   word_t       expDataQ [$];
   pc_t         expPcQ [$];
   int          progLen;
   int          branchPc;
   int          jumpPc;
   int          markerPc;
   int          valueErrors;
   int          otherErrors;
   int          storeCount;
   int          cycles;
   logic        markerSeen;
   logic [31:0] rngState;

   clockGen u_clockGen (.clk(clk), .rst(rst));

   riscvCore u_dut (.clk(clk), .rst(rst), .stall(stall), .imemAddr(imemAddr),
      .imemRdata(imemRdata), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe),
      .dmemRe(dmemRe), .dmemRdata(dmemRdata));

   // Synchronous memories, one cycle from address to data
   always @(posedge clk)
   begin
      imemRdata <= imem[imemAddr[`PC_WIDTH-1:2]];
      if (dmemWe)
         dmem[dmemAddr[`PC_WIDTH-1:2]] <= dmemWdata;
      if (dmemRe)
         dmemRdata <= dmem[dmemAddr[`PC_WIDTH-1:2]];
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic word_t fillWord(input int idx);
      return (word_t'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
   endfunction

   // Assembler helpers, each appends one word to the program image
   task automatic put(input word_t w);
      imem[progLen] = w;
      progLen++;
   endtask

   task automatic aluReg(input logic [2:0] f3, input logic alt, input int rd, input int rs1,
      input int rs2);
      put({1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
   endtask

   // Shift immediates carry the arithmetic flag in bit 10
   task automatic aluImm(input logic [2:0] f3, input int rd, input int rs1, input int imm);
      put({12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011});
   endtask

   task automatic lw(input int rd, input int rs1, input int imm);
      put({12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011});
   endtask

   task automatic sw(input int rs2, input int rs1, input int imm);
      logic [11:0] i;
      i = 12'(imm);
      put({i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011});
   endtask

   task automatic branch(input logic [2:0] f3, input int rs1, input int rs2, input int off);
      logic [12:0] o;
      o = 13'(off);
      put({o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011});
   endtask

   task automatic lui(input int rd, input int imm);
      put({20'(imm), 5'(rd), 7'b0110111});
   endtask

   task automatic auipc(input int rd, input int imm);
      put({20'(imm), 5'(rd), 7'b0010111});
   endtask

   task automatic jal(input int rd, input int off);
      logic [20:0] o;
      o = 21'(off);
      put({o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111});
   endtask

   task automatic jalr(input int rd, input int rs1, input int imm);
      put({12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b1100111});
   endtask

   task automatic loadProgram();
      int loopPc;
      progLen = 0;
      aluImm(F_ADD, 10, 0, 256);
      aluImm(F_ADD, 11, 0, MARKER);
      lui(1, 'h12345);
      aluImm(F_ADD, 1, 1, 'h678);
      aluImm(F_ADD, 2, 0, -7);
      aluImm(F_ADD, 13, 0, 3);
      // ALU loop, x1 scrambled by xorshift each pass
      loopPc = progLen * 4;
      aluReg(F_ADD, 0, 3, 1, 2);
      sw(3, 10, 0);
      aluReg(F_ADD, 1, 4, 2, 1);
      sw(4, 10, 4);
      aluReg(F_SLL, 0, 5, 1, 2);
      aluReg(F_SR, 0, 6, 4, 2);
      aluReg(F_SR, 1, 7, 4, 2);
      aluReg(F_XOR, 0, 5, 5, 6);
      aluReg(F_OR, 0, 5, 5, 7);
      sw(5, 10, 12);
      aluReg(F_SLT, 0, 8, 4, 3);
      aluReg(F_SLTU, 0, 9, 4, 3);
      aluReg(F_AND, 0, 6, 3, 4);
      aluImm(F_SLL, 8, 8, 1);
      aluReg(F_OR, 0, 8, 8, 9);
      sw(8, 10, 12);
      sw(6, 10, 12);
      aluImm(F_XOR, 6, 3, -1365);
      aluImm(F_OR, 7, 4, 'h0F0);
      aluImm(F_AND, 8, 1, 'h7F3);
      aluImm(F_SLT, 9, 2, 5);
      aluImm(F_SLTU, 5, 2, 5);
      aluImm(F_SR, 3, 4, 'h403);
      aluImm(F_SR, 4, 4, 7);
      aluReg(F_ADD, 0, 6, 6, 7);
      aluReg(F_XOR, 0, 6, 6, 8);
      aluReg(F_ADD, 0, 9, 9, 5);
      aluReg(F_XOR, 0, 3, 3, 4);
      sw(9, 10, 12);
      sw(6, 10, 12);
      sw(3, 10, 12);
      // Load right after a store, then load-use on both loads
      lw(14, 10, 0);
      aluImm(F_ADD, 14, 14, 1);
      lw(15, 10, 512);
      aluReg(F_ADD, 0, 14, 14, 15);
      sw(14, 10, 8);
      aluImm(F_SLL, 15, 1, 13);
      aluReg(F_XOR, 0, 1, 1, 15);
      aluImm(F_SR, 15, 1, 17);
      aluReg(F_XOR, 0, 1, 1, 15);
      aluImm(F_ADD, 2, 2, 3);
      aluImm(F_ADD, 10, 10, 16);
      aluImm(F_ADD, 13, 13, -1);
      branch(F_BNE, 13, 0, loopPc - progLen * 4);
      // Every taken branch skips a store of x1 that must never appear
      branchPc = progLen * 4;
      branch(F_BEQ, 13, 0, 8);
      sw(1, 10, 0);
      branch(F_BLT, 13, 2, 8);
      sw(1, 10, 0);
      branch(F_BGE, 13, 2, 8);
      sw(2, 10, 4);
      aluImm(F_ADD, 16, 0, -1);
      branch(F_BLTU, 16, 2, 8);
      sw(16, 10, 8);
      branch(F_BLT, 16, 2, 8);
      sw(1, 10, 0);
      branch(F_BGEU, 16, 2, 8);
      sw(1, 10, 0);
      branch(F_BNE, 13, 0, 8);
      sw(13, 10, 12);
      jumpPc = progLen * 4;
      jal(16, 8);
      sw(1, 10, 0);
      sw(16, 10, 0);
      auipc(17, 1);
      sw(17, 10, 4);
      // JALR lands three words on
      aluImm(F_ADD, 18, 0, progLen * 4 + 8);
      jalr(19, 18, 4);
      sw(1, 10, 0);
      sw(19, 10, 8);
      markerPc = progLen * 4;
      sw(2, 11, 0);
      jal(0, 0);
   endtask

   function automatic word_t aluRef(input logic [2:0] f3, input logic alt, input word_t a,
      input word_t b);
      logic [4:0] sh;
      sh = b[4:0];
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << sh;
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         3'd7:    return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   // Instruction-set model of the program, queues each store in order
   function automatic void riscvRef();
      word_t x [32];
      word_t instr;
      word_t a;
      word_t b;
      word_t res;
      word_t addr;
      word_t pc;
      word_t nextPc;
      logic  wr;
      logic  done;
      int    steps;
      foreach (x[r])
         x[r] = '0;
      pc = word_t'(`RESET_PC);
      done = 1'b0;
      steps = 0;
      while (!done && steps < MAX_CYCLES)
      begin
         instr = imem[pc[`PC_WIDTH-1:2]];
         a = x[instr[19:15]];
         b = x[instr[24:20]];
         nextPc = pc + 4;
         wr = 1'b1;
         res = '0;
         case (instr[6:0])
            7'b0110111: res = {instr[31:12], 12'b0};
            7'b0010111: res = pc + {instr[31:12], 12'b0};
            7'b1101111:
            begin
               res = pc + 4;
               nextPc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            7'b1100111:
            begin
               res = pc + 4;
               nextPc = (a + {{20{instr[31]}}, instr[31:20]}) & ~32'd1;
            end
            7'b1100011:
            begin
               wr = 1'b0;
               if (branchTaken(instr[14:12], a, b))
                  nextPc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            7'b0000011:
            begin
               addr = a + {{20{instr[31]}}, instr[31:20]};
               res = refMem[addr[`PC_WIDTH-1:2]];
            end
            7'b0100011:
            begin
               wr = 1'b0;
               addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
               refMem[addr[`PC_WIDTH-1:2]] = b;
               expAddrQ.push_back(addr[`PC_WIDTH-1:0]);
               expDataQ.push_back(b);
               expPcQ.push_back(pc[`PC_WIDTH-1:0]);
               done = (addr[`PC_WIDTH-1:0] == MARKER);
            end
            7'b0010011:
               res = aluRef(instr[14:12], instr[30] && instr[14:12] == 3'd5, a,
                  {{20{instr[31]}}, instr[31:20]});
            7'b0110011: res = aluRef(instr[14:12], instr[30], a, b);
            default:    wr = 1'b0;
         endcase
         if (wr && instr[11:7] != 5'd0)
            x[instr[11:7]] = res;
         pc = nextPc;
         steps++;
      end
      if (!done)
      begin
         $display("reference model never reached the marker store");
         otherErrors++;
      end
   endfunction

   function automatic string sectionName(input pc_t pc);
      if (pc < branchPc)
         return "aluLoop";
      else if (pc < jumpPc)
         return "branches";
      else if (pc < markerPc)
         return "jumps";
      else
         return "marker";
   endfunction

   task automatic checkIdle();
      assert (!dmemWe && !dmemRe)
      else
      begin
         $display("data memory strobe active during reset or the cycle after it");
         otherErrors++;
      end
      assert (imemAddr == `RESET_PC)
      else
      begin
         $display("error reset: imemAddr expected %h actual %h", `RESET_PC, imemAddr);
         valueErrors++;
      end
   endtask

   // Random back-pressure, high on about one cycle in four
   initial
   begin
      stall = 1'b0;
      rngState = 32'd40120;
      @(negedge rst);
      forever
      begin
         @(posedge clk);
         #1;
         rngState = xorshift32(rngState);
         stall = (rngState[1:0] == 2'b00);
      end
   end

   // Store checker, sampled mid-cycle
   always @(negedge clk)
   begin : compareStores
      pc_t   expAddr;
      word_t expData;
      string name;
      if (!rst)
      begin
         assert (!(stall && (dmemWe || dmemRe)))
         else
         begin
            $display("data memory request issued while stalled");
            otherErrors++;
         end
         if (dmemWe)
         begin
            storeCount++;
            assert (expAddrQ.size() != 0)
            else
            begin
               $display("store %0d to %h was not expected", storeCount, dmemAddr);
               otherErrors++;
            end
            if (expAddrQ.size() != 0)
            begin
               expAddr = expAddrQ.pop_front();
               expData = expDataQ.pop_front();
               name = sectionName(expPcQ.pop_front());
               assert (dmemAddr == expAddr)
               else
               begin
                  $display("error %s: store %0d address expected %h actual %h", name,
                     storeCount, expAddr, dmemAddr);
                  valueErrors++;
               end
               assert (dmemWdata == expData)
               else
               begin
                  $display("error %s: store %0d data expected %h actual %h", name,
                     storeCount, expData, dmemWdata);
                  valueErrors++;
               end
            end
            if (dmemAddr == MARKER)
               markerSeen = 1'b1;
         end
      end
   end

   initial
   begin
      imemRdata = '0;
      dmemRdata = '0;
      valueErrors = 0;
      otherErrors = 0;
      storeCount = 0;
      markerSeen = 1'b0;
      loadProgram();
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         dmem[i] = fillWord(i);
         refMem[i] = fillWord(i);
      end
      riscvRef();
      @(posedge clk);
      do
      begin
         @(negedge clk);
         checkIdle();
      end
      while (rst);
      cycles = 0;
      while (!markerSeen && cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!markerSeen)
      begin
         $display("timeout, no marker store within %0d cycles", MAX_CYCLES);
         otherErrors++;
      end
      assert (expAddrQ.size() == 0)
      else
      begin
         $display("%0d expected stores never arrived", expAddrQ.size());
         otherErrors++;
      end
      $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
